/* sim/pipe_trace.txt */
# M <pc hex> <word hex> | K <ack delay cycles> | B <start cycle> <length>
# E <expected retire pc hex>, in retire order
M 80000000 00100093
M 80000004 00200113
M 80000008 00003183
M 8000000c 00118213
M 80000010 00403423
M 80000014 0100006f
M 80000018 00500293
M 8000001c 00600313
M 80000020 00700393
M 80000024 00800413
M 80000028 00900493
M 8000002c 00a00513
M 80000030 00b00593
M 80000034 00c00613
K 2
B 6 3
B 24 4
E 80000000
E 80000004
E 80000008
E 8000000c
E 80000010
E 80000014
E 80000024
E 80000028
E 8000002c
E 80000030
E 80000034

/* list.f */
rtl/pipe_pkg.sv
rtl/pc_reg.sv
rtl/stage_reg.sv
rtl/inst_decode.sv
rtl/mem_access.sv
rtl/ctrl.sv
rtl/pipe_core.sv
sim/pipe_core_asserts.sv
sim/pipe_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert --top-module pipe_core_tb -f list.f -o pipe_sim \
    && ./obj_dir/pipe_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation not ok"; exit 1; }

/* sim/pipe_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
    import pipe_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
    // addi x0, x0, 0 for unmapped fetches
    localparam logic [INST_W-1:0] NOP = 32'h0000_0013;
    // test slots
    localparam int T_RESET = 0;
    localparam int T_ALU   = 1;
    localparam int T_JAL   = 2;
    localparam int T_MEM   = 3;
    localparam int T_BUSY  = 4;
    localparam int T_SEQ   = 5;

    logic              clk;
    logic              reset_i;
    logic              axi_busy_i;
    logic              axi_busy_end_i;
    logic              mem_ack_i;
    logic              mem_req_o;
    logic              retire_valid_o;
    logic [XLEN-1:0]   pc_o;
    logic [XLEN-1:0]   retire_pc_o;
    logic [INST_W-1:0] inst_i;

    // program image and trace contents
    logic [INST_W-1:0] imem [logic [XLEN-1:0]];
    logic [XLEN-1:0]   exp_pc [$];
    int                busy_start [$];
    int                busy_len [$];
    int                ack_delay;
    int                cyc;
    int                exp_idx;
    int                checks;
    int                errs [6] = '{default: 0};
    string names [6] = '{"reset_state", "straight_alu", "jal_redirect",
                         "load_store", "busy_window", "full_sequence"};
    bit                loaded;
    bit                seq_done;
    bit                have_prev;
    bit                prev_busy;
    bit                req_seen;
    bit                acked;
    logic [XLEN-1:0]   prev_pc;
    logic [XLEN-1:0]   held_pc;

    always #4 clk = ~clk;

    pipe_core #(.RESET_PC(RESET_PC)) dut (
        .clk(clk), .reset_i(reset_i), .pc_o(pc_o), .inst_i(inst_i),
        .axi_busy_i(axi_busy_i), .axi_busy_end_i(axi_busy_end_i),
        .mem_ack_i(mem_ack_i), .mem_req_o(mem_req_o),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o)
    );

    function automatic logic [INST_W-1:0] fetch_word(logic [XLEN-1:0] pc);
        return imem.exists(pc) ? imem[pc] : NOP;
    endfunction

    // instruction memory answers in the same cycle
    always_comb inst_i = fetch_word(pc_o);

    // pc relative j-type target rebuilt from the word
    function automatic logic [XLEN-1:0] jal_target(logic [XLEN-1:0] pc, logic [INST_W-1:0] w);
        logic [XLEN-1:0] offs;
        offs = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        return pc + offs;
    endfunction

    function automatic bit is_mem_op(logic [INST_W-1:0] w);
        return (w[6:0] == 7'h03) || (w[6:0] == 7'h23);
    endfunction

    // last_only picks the end pulse cycle of a window
    function automatic bit in_window(int c, bit last_only);
        foreach (busy_start[i]) begin
            if (!last_only && c >= busy_start[i] && c < busy_start[i] + busy_len[i])
                return 1'b1;
            if (last_only && c == busy_start[i] + busy_len[i] - 1)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int busy_total();
        int sum;
        sum = 0;
        foreach (busy_len[i])
            sum += busy_len[i];
        return sum;
    endfunction

    task automatic check_value(input int t, input logic [63:0] exp_v, input logic [63:0] act_v);
        checks++;
        assert (exp_v === act_v) else begin
            $display("[ERROR] %s: expected %h, actual %h", names[t], exp_v, act_v);
            errs[t]++;
        end
    endtask

    task automatic load_trace(output bit ok);
        int fd;
        int n;
        int x;
        int y;
        string tag;
        string line;
        logic [XLEN-1:0] a;
        logic [INST_W-1:0] w;
        ok = 1'b0;
        fd = $fopen("sim/pipe_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file sim/pipe_trace.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "M") begin
                    n = $fscanf(fd, "%h %h", a, w);
                    imem[a] = w;
                end else if (tag == "K") begin
                    n = $fscanf(fd, "%d", ack_delay);
                end else if (tag == "B") begin
                    n = $fscanf(fd, "%d %d", x, y);
                    busy_start.push_back(x);
                    busy_len.push_back(y);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h", a);
                    exp_pc.push_back(a);
                end else begin
                    // skip the rest of a comment line
                    n = $fgets(line, fd);
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic record_retire(input logic [XLEN-1:0] pc);
        logic [INST_W-1:0] pw;
        check_value(T_SEQ, exp_pc[exp_idx], pc);
        if (have_prev) begin
            pw = fetch_word(prev_pc);
            // after a jal the skipped pcs must not show up
            if (pw[6:0] == 7'h6f)
                check_value(T_JAL, jal_target(prev_pc, pw), pc);
            else
                check_value(T_ALU, prev_pc + 64'd4, pc);
        end
        // every access raised a request and saw its ack
        check_value(T_MEM, 64'(is_mem_op(fetch_word(pc))), 64'(req_seen));
        if (req_seen)
            check_value(T_MEM, 64'd1, 64'(acked));
        req_seen = 1'b0;
        acked = 1'b0;
        prev_pc = pc;
        have_prev = 1'b1;
        exp_idx++;
        if (exp_idx == exp_pc.size())
            seq_done = 1'b1;
    endtask

    // busy windows counted in cycles after reset
    always @(posedge clk) begin
        if (reset_i) begin
            cyc <= 0;
        end else begin
            axi_busy_i     <= in_window(cyc, 1'b0);
            axi_busy_end_i <= in_window(cyc, 1'b1);
            cyc            <= cyc + 1;
        end
    end

    // ack pulse a fixed delay after the request shows up
    initial begin
        wait (loaded);
        forever begin
            @(negedge clk);
            if (mem_req_o) begin
                repeat (ack_delay) @(posedge clk);
                mem_ack_i <= 1'b1;
                @(posedge clk);
                mem_ack_i <= 1'b0;
                @(negedge clk);
                while (mem_req_o) @(negedge clk);
            end
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (!reset_i && loaded && !seq_done) begin
            if (prev_busy)
                check_value(T_BUSY, held_pc, pc_o);
            if (axi_busy_i && !axi_busy_end_i)
                check_value(T_BUSY, '0, 64'(retire_valid_o));
            if (mem_req_o) begin
                req_seen = 1'b1;
                check_value(T_MEM, '0, 64'(retire_valid_o));
                if (mem_ack_i)
                    acked = 1'b1;
            end
            if (retire_valid_o)
                record_retire(retire_pc_o);
            prev_busy = axi_busy_i && !axi_busy_end_i;
            held_pc = pc_o;
        end
    end

    // limit scales with trace length
    initial begin
        wait (loaded);
        #((exp_pc.size() * (ack_delay + 6) + busy_total() + 50) * 8);
        $display("timeout: expected retire pc %h (entry %0d) was never retired",
                 exp_pc[exp_idx], exp_idx);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int failed;
        bit trace_ok;
        clk = 1'b0;
        reset_i = 1'b1;
        axi_busy_i = 1'b0;
        axi_busy_end_i = 1'b0;
        mem_ack_i = 1'b0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Regression failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            reset_i <= 1'b0;
            @(negedge clk);
            check_value(T_RESET, RESET_PC, pc_o);
            check_value(T_RESET, '0, 64'(mem_req_o));
            check_value(T_RESET, '0, 64'(retire_valid_o));
            $display("test %-14s %s, %0d error(s)", names[T_RESET],
                     errs[T_RESET] == 0 ? "ok" : "FAILED", errs[T_RESET]);
            wait (seq_done);
            failed = (errs[T_RESET] != 0) ? 1 : 0;
            for (int t = 1; t < 6; t++) begin
                $display("test %-14s %s, %0d error(s)", names[t],
                         errs[t] == 0 ? "ok" : "FAILED", errs[t]);
                if (errs[t] != 0)
                    failed++;
            end
            $display("%0d checks, %0d of 6 tests passed", checks, 6 - failed);
            if (failed == 0)
                $display("Regression passed");
            else
                $display("Regression failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/pipe_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core_asserts (
    input wire clk,
    input wire reset_i,
    input wire busy_i,
    input wire busy_end_i,
    input wire jump_en_i,
    input wire if_id_stall_i,
    input wire if_id_flush_i,
    input wire id_ex_stall_i,
    input wire id_ex_flush_i,
    input wire load_pending_i,
    input wire store_pending_i,
    input wire mem_req_i,
    input wire mem_ack_i
);

    // one action per stage
    assert property (@(posedge clk) disable iff (reset_i) !(if_id_stall_i && if_id_flush_i))
        else $error("if_id stalled and flushed together");
    assert property (@(posedge clk) disable iff (reset_i) !(id_ex_stall_i && id_ex_flush_i))
        else $error("id_ex stalled and flushed together");

    // jal ranks below busy and pending access
    assert property (@(posedge clk) disable iff (reset_i)
        !(jump_en_i && ((busy_i && !busy_end_i) || load_pending_i || store_pending_i)))
        else $error("jump raised while busy or access pending");

    // request level only drops after an ack
    assert property (@(posedge clk) disable iff (reset_i) mem_req_i && !mem_ack_i |=> mem_req_i)
        else $error("mem request dropped without ack");

endmodule

bind pipe_core pipe_core_asserts u_asserts (
    .clk(clk), .reset_i(reset_i), .busy_i(axi_busy_i), .busy_end_i(axi_busy_end_i),
    .jump_en_i(jump_en), .if_id_stall_i(if_id_stall), .if_id_flush_i(if_id_flush),
    .id_ex_stall_i(id_ex_stall), .id_ex_flush_i(id_ex_flush),
    .load_pending_i(mem_load_pending), .store_pending_i(mem_store_pending),
    .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i)
);

`default_nettype wire

/* rtl/pipe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core
    import pipe_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire              clk,
    input  wire              reset_i,
    // instruction fetch
    output logic [XLEN-1:0]  pc_o,
    input  wire [INST_W-1:0] inst_i,
    // bus busy window
    input  wire              axi_busy_i,
    input  wire              axi_busy_end_i,
    // data memory
    input  wire              mem_ack_i,
    output logic             mem_req_o,
    // completion
    output logic             retire_valid_o,
    output logic [XLEN-1:0]  retire_pc_o
);

    // control
    logic              pc_stall;
    logic              jump_en;
    logic [XLEN-1:0]   jump_addr;
    logic              if_id_stall;
    logic              if_id_flush;
    logic              id_ex_stall;
    logic              id_ex_flush;
    logic              mem_stall;
    logic              mem_load_pending;
    logic              mem_store_pending;

    // decode stage token
    logic              if_id_valid;
    logic [XLEN-1:0]   if_id_pc;
    logic [INST_W-1:0] if_id_inst;

    // execute stage token and its decode
    logic              ex_valid;
    logic [XLEN-1:0]   ex_pc;
    logic [INST_W-1:0] ex_inst;
    logic [KIND_W-1:0] ex_kind;
    logic [XLEN-1:0]   ex_target;

    pc_reg #(
        .RESET_PC(RESET_PC)
    ) u_pc_reg (
        .clk(clk), .reset_i(reset_i), .stall_i(pc_stall),
        .jump_en_i(jump_en), .jump_addr_i(jump_addr), .pc_o(pc_o)
    );

    // every fetch is a valid token
    stage_reg if_id (
        .clk(clk), .reset_i(reset_i), .stall_i(if_id_stall), .flush_i(if_id_flush),
        .valid_i(1'b1), .pc_i(pc_o), .inst_i(inst_i),
        .valid_o(if_id_valid), .pc_o(if_id_pc), .inst_o(if_id_inst)
    );

    stage_reg id_ex (
        .clk(clk), .reset_i(reset_i), .stall_i(id_ex_stall), .flush_i(id_ex_flush),
        .valid_i(if_id_valid), .pc_i(if_id_pc), .inst_i(if_id_inst),
        .valid_o(ex_valid), .pc_o(ex_pc), .inst_o(ex_inst)
    );

    inst_decode u_inst_decode (
        .valid_i(ex_valid), .pc_i(ex_pc), .inst_i(ex_inst),
        .kind_o(ex_kind), .target_o(ex_target)
    );

    mem_access u_mem_access (
        .clk(clk), .reset_i(reset_i), .stall_i(mem_stall),
        .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_kind_i(ex_kind),
        .mem_ack_i(mem_ack_i), .mem_req_o(mem_req_o),
        .load_pending_o(mem_load_pending), .store_pending_o(mem_store_pending),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o)
    );

    ctrl u_ctrl (
        .axi_busy_i(axi_busy_i), .axi_busy_end_i(axi_busy_end_i),
        .ex_valid_i(ex_valid), .ex_kind_i(ex_kind), .ex_target_i(ex_target),
        .mem_load_pending_i(mem_load_pending), .mem_store_pending_i(mem_store_pending),
        .jump_en_o(jump_en), .jump_addr_o(jump_addr), .pc_stall_o(pc_stall),
        .if_id_stall_o(if_id_stall), .if_id_flush_o(if_id_flush),
        .id_ex_stall_o(id_ex_stall), .id_ex_flush_o(id_ex_flush),
        .mem_stall_o(mem_stall)
    );

endmodule

`default_nettype wire

/* rtl/ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl
    import pipe_pkg::*;
(
    // from axi
    input  wire              axi_busy_i,
    input  wire              axi_busy_end_i,
    // from ex
    input  wire              ex_valid_i,
    input  wire [KIND_W-1:0] ex_kind_i,
    input  wire [XLEN-1:0]   ex_target_i,
    // from mem
    input  wire              mem_load_pending_i,
    input  wire              mem_store_pending_i,
    // to pc_reg
    output logic             jump_en_o,
    output logic [XLEN-1:0]  jump_addr_o,
    output logic             pc_stall_o,
    // to if_id
    output logic             if_id_stall_o,
    output logic             if_id_flush_o,
    // to id_ex
    output logic             id_ex_stall_o,
    output logic             id_ex_flush_o,
    // to mem stage
    output logic             mem_stall_o
);

    logic busy;
    logic mem_pending;
    logic ex_jal;
    logic ex_mem_op;

    // end pulse cycle already lets the pipe move
    assign busy        = axi_busy_i && !axi_busy_end_i;
    assign mem_pending = mem_load_pending_i || mem_store_pending_i;
    assign ex_jal      = ex_valid_i && (ex_kind_i == KIND_JAL);
    assign ex_mem_op   = ex_valid_i && ((ex_kind_i == KIND_LOAD) || (ex_kind_i == KIND_STORE));

    always_comb begin
        jump_en_o     = 1'b0;
        jump_addr_o   = '0;
        pc_stall_o    = 1'b0;
        if_id_stall_o = 1'b0;
        if_id_flush_o = 1'b0;
        id_ex_stall_o = 1'b0;
        id_ex_flush_o = 1'b0;
        mem_stall_o   = 1'b0;
        if (busy) begin
            // freeze everything, execute token kept in place
            pc_stall_o    = 1'b1;
            if_id_stall_o = 1'b1;
            id_ex_stall_o = 1'b1;
            mem_stall_o   = 1'b1;
        end else if (mem_pending) begin
            // wait for ack, execute is already a bubble here
            pc_stall_o    = 1'b1;
            if_id_stall_o = 1'b1;
            id_ex_flush_o = 1'b1;
            mem_stall_o   = 1'b1;
        end else if (ex_jal) begin
            // drop the two younger fetches, redirect pc
            jump_en_o     = 1'b1;
            jump_addr_o   = ex_target_i;
            if_id_flush_o = 1'b1;
            id_ex_flush_o = 1'b1;
        end else if (ex_mem_op) begin
            // access moves to mem, bubble behind it
            // also covers every load-use pair
            pc_stall_o    = 1'b1;
            if_id_stall_o = 1'b1;
            id_ex_flush_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import pipe_pkg::*;
(
    input  wire              clk,
    input  wire              reset_i,
    // from ctrl
    input  wire              stall_i,
    // token leaving execute
    input  wire              ex_valid_i,
    input  wire [XLEN-1:0]   ex_pc_i,
    input  wire [KIND_W-1:0] ex_kind_i,
    // memory side
    input  wire              mem_ack_i,
    output logic             mem_req_o,
    // to ctrl
    output logic             load_pending_o,
    output logic             store_pending_o,
    // completion
    output logic             retire_valid_o,
    output logic [XLEN-1:0]  retire_pc_o
);

    logic              mem_valid;
    logic [XLEN-1:0]   mem_pc;
    logic [KIND_W-1:0] mem_kind;
    // access already acknowledged, waiting to advance
    logic              mem_done;

    // ex/mem register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_valid <= 1'b0;
        end else if (!stall_i) begin
            mem_valid <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_pc   <= ex_pc_i;
            mem_kind <= ex_kind_i;
        end
    end

    // ack only counts while the request is up
    always_ff @(posedge clk) begin
        if (reset_i || !stall_i) begin
            mem_done <= 1'b0;
        end else if (mem_req_o && mem_ack_i) begin
            mem_done <= 1'b1;
        end
    end

    assign load_pending_o  = mem_valid && (mem_kind == KIND_LOAD) && !mem_done;
    assign store_pending_o = mem_valid && (mem_kind == KIND_STORE) && !mem_done;
    // request level stays up until the ack lands
    assign mem_req_o       = load_pending_o || store_pending_o;

    // a token retires in the cycle the stage advances
    assign retire_valid_o = mem_valid && !stall_i;
    assign retire_pc_o    = mem_pc;

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode
    import pipe_pkg::*;
(
    // token held in execute
    input  wire              valid_i,
    input  wire [XLEN-1:0]   pc_i,
    input  wire [INST_W-1:0] inst_i,
    // class and jal destination
    output logic [KIND_W-1:0] kind_o,
    output logic [XLEN-1:0]   target_o
);

    logic [6:0]  opcode;
    logic [20:0] j_imm;

    assign opcode = inst_i[6:0];

    // j-type immediate, bit 0 always zero
    assign j_imm = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // pc relative, sign extended to full width
    assign target_o = pc_i + {{(XLEN-21){j_imm[20]}}, j_imm};

    // bubble reads as alu so nothing downstream reacts
    always_comb begin
        kind_o = KIND_ALU;
        if (valid_i) begin
            case (opcode)
                OPC_LOAD:  kind_o = KIND_LOAD;
                OPC_STORE: kind_o = KIND_STORE;
                OPC_JAL:   kind_o = KIND_JAL;
                default:   kind_o = KIND_ALU;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg
    import pipe_pkg::*;
(
    input  wire              clk,
    input  wire              reset_i,
    // from ctrl
    input  wire              stall_i,
    input  wire              flush_i,
    // token from the older side
    input  wire              valid_i,
    input  wire [XLEN-1:0]   pc_i,
    input  wire [INST_W-1:0] inst_i,
    // token to the younger side
    output logic              valid_o,
    output logic [XLEN-1:0]   pc_o,
    output logic [INST_W-1:0] inst_o
);

    // flush wins over stall, bubble is just valid low
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    // payload, only the valid bit matters for a bubble
    always_ff @(posedge clk) begin
        if (!stall_i && !flush_i) begin
            pc_o   <= pc_i;
            inst_o <= inst_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_reg
    import pipe_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire            clk,
    input  wire            reset_i,
    // from ctrl
    input  wire            stall_i,
    input  wire            jump_en_i,
    input  wire [XLEN-1:0] jump_addr_i,
    // fetch address
    output logic [XLEN-1:0] pc_o
);

    // jump first, then hold, else sequential step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= RESET_PC;
        end else if (jump_en_i) begin
            pc_o <= jump_addr_i;
        end else if (!stall_i) begin
            pc_o <= pc_o + XLEN'(4);
        end
    end

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // address and pc width
    localparam int XLEN = 64;

    // fetched instruction word
    localparam int INST_W = 32;

    // instruction class code width
    localparam int KIND_W = 2;

    // instruction classes seen by the hazard logic
    localparam logic [KIND_W-1:0] KIND_ALU   = 2'd0;
    localparam logic [KIND_W-1:0] KIND_LOAD  = 2'd1;
    localparam logic [KIND_W-1:0] KIND_STORE = 2'd2;
    localparam logic [KIND_W-1:0] KIND_JAL   = 2'd3;

    // rv64 major opcodes, bits [6:0] of the word
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;

endpackage

`default_nettype wire
